//--- Makefile
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= cache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= test failed
PASS_MSG  ?= test passed
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported errors"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- cache.f
logic/cache_pkg.sv
logic/cache_req_if.sv
logic/req_fifo.sv
logic/plru_tree.sv
logic/cache_ctrl.sv
logic/cache_top.sv
tb/cache_props.sv
tb/cache_tb.sv

//--- logic/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
    input  logic             i_clk,
    input  logic             i_rst_n,
    cache_req_if.ctrl_side   q,
    output logic             o_lookup_valid,
    output logic             o_lookup_hit,
    output logic             o_rsp_valid,
    output cache_pkg::data_t o_rsp_data,
    output logic             o_mem_req_valid,
    input  logic             i_mem_req_ready,
    output logic             o_mem_req_write,
    output cache_pkg::addr_t o_mem_req_addr,
    output cache_pkg::data_t o_mem_req_data,
    input  logic             i_mem_rsp_valid,
    input  cache_pkg::data_t i_mem_rsp_data
);

    cache_pkg::ctrl_state_e state;
    logic                   pop_ready;
    cache_pkg::req_op_e     req_op;     // Request being served
    cache_pkg::addr_t       req_addr;
    cache_pkg::data_t       req_data;
    cache_pkg::be_t         req_be;
    cache_pkg::way_t        victim_q;

    cache_pkg::tag_t        tag_arr   [cache_pkg::SETS][cache_pkg::WAYS];
    cache_pkg::data_t       data_arr  [cache_pkg::SETS][cache_pkg::WAYS];
    cache_pkg::line_state_e state_arr [cache_pkg::SETS][cache_pkg::WAYS];

    cache_pkg::tag_t            req_tag;
    cache_pkg::index_t          req_index;
    logic [cache_pkg::WAYS-1:0] hit_vec;
    logic                       hit;
    cache_pkg::way_t            hit_way;
    cache_pkg::way_t            plru_victim;
    logic                       victim_dirty;
    logic                       line_we;
    cache_pkg::way_t            line_way;
    cache_pkg::data_t           line_data;
    cache_pkg::line_state_e     line_st;
    logic                       touch;

    function automatic cache_pkg::data_t merge_bytes(input cache_pkg::data_t old_word,
                                                     input cache_pkg::data_t new_word,
                                                     input cache_pkg::be_t   be);
        cache_pkg::data_t result;
        result = old_word;
        for (int b = 0; b < cache_pkg::BE_W; b++) begin
            if (be[b]) result[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return result;
    endfunction

    assign req_tag   = req_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
    assign req_index = req_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];

    ////////////////////////////////////////
    // Tag compare
    ////////////////////////////////////////
    always_comb begin
        hit_vec = '0;
        hit_way = '0;
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
            if (state_arr[req_index][w] != cache_pkg::LINE_INVALID &&
                tag_arr[req_index][w] == req_tag) begin
                hit_vec[w] = 1'b1;
                hit_way    = cache_pkg::way_t'(w);
            end
        end
    end

    assign hit            = |hit_vec;
    assign victim_dirty   = (state_arr[req_index][plru_victim] == cache_pkg::LINE_MODIFIED);
    assign o_lookup_valid = (state == cache_pkg::ST_LOOKUP);
    assign o_lookup_hit   = o_lookup_valid && hit;
    assign q.ready        = pop_ready;

    ////////////////////////////////////////
    // Line update
    ////////////////////////////////////////
    always_comb begin
        line_we   = 1'b0;
        line_way  = victim_q;
        line_data = i_mem_rsp_data;  // Refill by default
        line_st   = cache_pkg::LINE_EXCLUSIVE;
        case (state)
            cache_pkg::ST_LOOKUP: begin
                if (hit && req_op == cache_pkg::OP_WRITE) begin
                    line_we   = 1'b1;
                    line_way  = hit_way;
                    line_data = merge_bytes(data_arr[req_index][hit_way], req_data, req_be);
                    line_st   = cache_pkg::LINE_MODIFIED;
                end else if (!hit && !victim_dirty && req_op == cache_pkg::OP_WRITE) begin
                    line_we   = 1'b1;  // Clean victim is installed at once
                    line_way  = plru_victim;
                    line_data = merge_bytes('0, req_data, req_be);
                    line_st   = cache_pkg::LINE_MODIFIED;
                end
            end
            cache_pkg::ST_WRITEBACK: begin
                if (i_mem_req_ready && req_op == cache_pkg::OP_WRITE) begin
                    line_we   = 1'b1;
                    line_data = merge_bytes('0, req_data, req_be);
                    line_st   = cache_pkg::LINE_MODIFIED;
                end
            end
            cache_pkg::ST_REFILL_WAIT: line_we = i_mem_rsp_valid;
            default: line_we = 1'b0;
        endcase
    end

    assign touch = line_we || o_lookup_hit;

    plru_tree u_plru (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_index      (req_index),
        .i_touch      (touch),
        .i_touch_way  (line_we ? line_way : hit_way),
        .o_victim_way (plru_victim)
    );

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int s = 0; s < cache_pkg::SETS; s++) begin
                for (int w = 0; w < cache_pkg::WAYS; w++) begin
                    state_arr[s][w] <= cache_pkg::LINE_INVALID;
                end
            end
        end else if (line_we) begin
            state_arr[req_index][line_way] <= line_st;
        end
    end

    always_ff @(posedge i_clk) begin
        if (line_we) begin
            tag_arr[req_index][line_way]  <= req_tag;
            data_arr[req_index][line_way] <= line_data;
        end
    end

    ////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state           <= cache_pkg::ST_IDLE;
            pop_ready       <= 1'b0;
            o_rsp_valid     <= 1'b0;
            o_mem_req_valid <= 1'b0;
        end else begin
            o_rsp_valid <= 1'b0;
            case (state)
                cache_pkg::ST_IDLE: begin
                    pop_ready <= 1'b1;
                    if (q.valid && pop_ready) begin
                        pop_ready <= 1'b0;
                        state     <= cache_pkg::ST_LOOKUP;
                    end
                end
                cache_pkg::ST_LOOKUP: begin
                    if (hit || (!victim_dirty && req_op == cache_pkg::OP_WRITE)) begin
                        o_rsp_valid <= hit && (req_op == cache_pkg::OP_READ);
                        pop_ready   <= 1'b1;
                        state       <= cache_pkg::ST_IDLE;
                    end else begin
                        o_mem_req_valid <= 1'b1;
                        state <= victim_dirty ? cache_pkg::ST_WRITEBACK : cache_pkg::ST_REFILL_REQ;
                    end
                end
                cache_pkg::ST_WRITEBACK: begin
                    if (i_mem_req_ready && req_op == cache_pkg::OP_READ) begin
                        state <= cache_pkg::ST_REFILL_REQ;  // Read follows the writeback
                    end else if (i_mem_req_ready) begin
                        o_mem_req_valid <= 1'b0;
                        pop_ready       <= 1'b1;
                        state           <= cache_pkg::ST_IDLE;
                    end
                end
                cache_pkg::ST_REFILL_REQ: begin
                    if (i_mem_req_ready) begin
                        o_mem_req_valid <= 1'b0;
                        state           <= cache_pkg::ST_REFILL_WAIT;
                    end
                end
                cache_pkg::ST_REFILL_WAIT: begin
                    if (i_mem_rsp_valid) begin
                        o_rsp_valid <= 1'b1;
                        pop_ready   <= 1'b1;
                        state       <= cache_pkg::ST_IDLE;
                    end
                end
                default: state <= cache_pkg::ST_IDLE;
            endcase
        end
    end

    // Request, response and memory payload
    always_ff @(posedge i_clk) begin
        if (state == cache_pkg::ST_IDLE && q.valid && pop_ready) begin
            req_op   <= q.op;
            req_addr <= q.addr;
            req_data <= q.data;
            req_be   <= q.be;
        end
        if (state == cache_pkg::ST_LOOKUP) begin
            victim_q        <= plru_victim;
            o_rsp_data      <= data_arr[req_index][hit_way];
            o_mem_req_write <= victim_dirty;
            o_mem_req_data  <= data_arr[req_index][plru_victim];
            o_mem_req_addr  <= victim_dirty ?
                {tag_arr[req_index][plru_victim], req_index, {cache_pkg::OFFSET_W{1'b0}}} :
                {req_tag, req_index, {cache_pkg::OFFSET_W{1'b0}}};
        end
        if (state == cache_pkg::ST_WRITEBACK && i_mem_req_ready) begin
            o_mem_req_write <= 1'b0;
            o_mem_req_addr  <= {req_tag, req_index, {cache_pkg::OFFSET_W{1'b0}}};
        end
        if (state == cache_pkg::ST_REFILL_WAIT && i_mem_rsp_valid) begin
            o_rsp_data <= i_mem_rsp_data;
        end
    end

endmodule

//--- logic/cache_pkg.sv
package cache_pkg;

    ////////////////////////////////////////
    // Cache geometry
    ////////////////////////////////////////
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int BE_W       = DATA_W / 8;
    localparam int WAYS       = 4;
    localparam int SETS       = 16;
    localparam int WAY_W      = 2;
    localparam int INDEX_W    = 4;
    localparam int OFFSET_W   = 2;  // Byte offset, ignored
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [BE_W-1:0]       be_t;
    typedef logic [WAY_W-1:0]      way_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [WAYS-2:0]       plru_t;      // Tree bits of one set
    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } req_op_e;

    // Encoding 2'b10 is unused
    typedef enum logic [1:0] {
        LINE_MODIFIED  = 2'b00,
        LINE_EXCLUSIVE = 2'b01,
        LINE_INVALID   = 2'b11
    } line_state_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL_REQ,
        ST_REFILL_WAIT
    } ctrl_state_e;

endpackage

//--- logic/cache_req_if.sv
`timescale 1ns/1ps

interface cache_req_if;

    logic               valid;  // Head entry present
    logic               ready;  // Controller takes the head
    cache_pkg::req_op_e op;
    cache_pkg::addr_t   addr;
    cache_pkg::data_t   data;
    cache_pkg::be_t     be;

    // Queue presents the head entry
    modport queue_side (
        output valid, op, addr, data, be,
        input  ready
    );

    modport ctrl_side (
        input  valid, op, addr, data, be,
        output ready
    );

endinterface

//--- logic/cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic             i_clk,
    input  logic             i_rst_n,
    // Bus requester
    input  logic             i_req_valid,
    output logic             o_req_ready,
    input  logic             i_req_write,
    input  cache_pkg::addr_t i_req_addr,
    input  cache_pkg::data_t i_req_data,
    input  cache_pkg::be_t   i_req_be,
    output logic             o_rsp_valid,
    output cache_pkg::data_t o_rsp_data,
    output logic             o_lookup_valid,
    output logic             o_lookup_hit,
    // Memory port
    output logic             o_mem_req_valid,
    input  logic             i_mem_req_ready,
    output logic             o_mem_req_write,
    output cache_pkg::addr_t o_mem_req_addr,
    output cache_pkg::data_t o_mem_req_data,
    input  logic             i_mem_rsp_valid,
    input  cache_pkg::data_t i_mem_rsp_data
);

    cache_req_if req_if ();  // Queue head to controller

    req_fifo u_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_req_valid),
        .o_ready (o_req_ready),
        .i_write (i_req_write),
        .i_addr  (i_req_addr),
        .i_data  (i_req_data),
        .i_be    (i_req_be),
        .q       (req_if)
    );

    cache_ctrl u_ctrl (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .q               (req_if),
        .o_lookup_valid  (o_lookup_valid),
        .o_lookup_hit    (o_lookup_hit),
        .o_rsp_valid     (o_rsp_valid),
        .o_rsp_data      (o_rsp_data),
        .o_mem_req_valid (o_mem_req_valid),
        .i_mem_req_ready (i_mem_req_ready),
        .o_mem_req_write (o_mem_req_write),
        .o_mem_req_addr  (o_mem_req_addr),
        .o_mem_req_data  (o_mem_req_data),
        .i_mem_rsp_valid (i_mem_rsp_valid),
        .i_mem_rsp_data  (i_mem_rsp_data)
    );

endmodule

//--- logic/plru_tree.sv
`timescale 1ns/1ps

module plru_tree (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  cache_pkg::index_t i_index,
    input  logic              i_touch,
    input  cache_pkg::way_t   i_touch_way,
    output cache_pkg::way_t   o_victim_way
);

    cache_pkg::plru_t plru_bits [cache_pkg::SETS];
    cache_pkg::plru_t cur_bits;
    cache_pkg::plru_t new_bits;

    assign cur_bits = plru_bits[i_index];

    // Root picks the half, then that half's bit picks the way
    assign o_victim_way = cur_bits[0] ? {1'b1, cur_bits[2]} : {1'b0, cur_bits[1]};

    // Point every bit on the path away from the touched way
    always_comb begin
        new_bits    = cur_bits;
        new_bits[0] = ~i_touch_way[1];
        if (i_touch_way[1]) begin
            new_bits[2] = ~i_touch_way[0];  // Ways 2-3
        end else begin
            new_bits[1] = ~i_touch_way[0];  // Ways 0-1
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int s = 0; s < cache_pkg::SETS; s++) begin
                plru_bits[s] <= '0;
            end
        end else if (i_touch) begin
            plru_bits[i_index] <= new_bits;
        end
    end

endmodule

//--- logic/req_fifo.sv
`timescale 1ns/1ps

module req_fifo (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_valid,
    output logic                o_ready,
    input  logic                i_write,
    input  cache_pkg::addr_t    i_addr,
    input  cache_pkg::data_t    i_data,
    input  cache_pkg::be_t      i_be,
    cache_req_if.queue_side     q
);

    cache_pkg::req_op_e   op_mem   [cache_pkg::FIFO_DEPTH];
    cache_pkg::addr_t     addr_mem [cache_pkg::FIFO_DEPTH];
    cache_pkg::data_t     data_mem [cache_pkg::FIFO_DEPTH];
    cache_pkg::be_t       be_mem   [cache_pkg::FIFO_DEPTH];

    cache_pkg::fifo_ptr_t wr_ptr;
    cache_pkg::fifo_ptr_t rd_ptr;
    cache_pkg::fifo_cnt_t count;
    logic                 push;
    logic                 pop;

    assign o_ready = (count != cache_pkg::fifo_cnt_t'(cache_pkg::FIFO_DEPTH));
    assign q.valid = (count != '0);
    assign push    = i_valid && o_ready;
    assign pop     = q.valid && q.ready;

    // Head entry straight from storage
    assign q.op   = op_mem[rd_ptr];
    assign q.addr = addr_mem[rd_ptr];
    assign q.data = data_mem[rd_ptr];
    assign q.be   = be_mem[rd_ptr];

    always_ff @(posedge i_clk) begin
        if (push) begin
            op_mem[wr_ptr]   <= i_write ? cache_pkg::OP_WRITE : cache_pkg::OP_READ;
            addr_mem[wr_ptr] <= i_addr;
            data_mem[wr_ptr] <= i_data;
            be_mem[wr_ptr]   <= i_be;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- tb/cache_props.sv
`timescale 1ns/1ps

module cache_props (
    input logic                   i_clk,
    input logic                   i_rst_n,
    input logic                   i_mem_req_valid,
    input logic                   i_mem_req_ready,
    input cache_pkg::addr_t       i_mem_req_addr,
    input cache_pkg::data_t       i_mem_req_data,
    input logic                   i_rsp_valid,
    input logic                   i_lookup_valid,
    input cache_pkg::ctrl_state_e i_state
);

    ////////////////////////////////////////
    // Memory request holds until accepted
    ////////////////////////////////////////
    a_mem_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_mem_req_valid && !i_mem_req_ready |=>
            i_mem_req_valid && $stable(i_mem_req_addr) && $stable(i_mem_req_data))
        else $error("Memory request dropped or changed before ready");

    // No read data while a victim is written back
    a_no_rsp_wb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_rsp_valid && i_state == cache_pkg::ST_WRITEBACK))
        else $error("Read response during writeback");

    a_lookup_reset: assert property (@(posedge i_clk) !i_rst_n |-> !i_lookup_valid)
        else $error("Lookup strobe during reset");

endmodule

bind cache_ctrl cache_props u_props (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_mem_req_valid (o_mem_req_valid),
    .i_mem_req_ready (i_mem_req_ready),
    .i_mem_req_addr  (o_mem_req_addr),
    .i_mem_req_data  (o_mem_req_data),
    .i_rsp_valid     (o_rsp_valid),
    .i_lookup_valid  (o_lookup_valid),
    .i_state         (state)
);

//--- tb/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

    localparam int          CLK_PERIOD = 20;
    localparam int          TIMEOUT    = 200;  // Cycles per wait
    localparam logic [31:0] MEM_KEY    = 32'h5a3c_96e1;
    localparam logic [31:0] SEED       = 32'h4bfd4866;

    logic        i_clk;
    logic        i_rst_n;
    logic        req_valid;
    logic        req_ready;
    logic        req_write;
    logic [31:0] req_addr;
    logic [31:0] req_data;
    logic [3:0]  req_be;
    logic        rsp_valid;
    logic [31:0] rsp_data;
    logic        lookup_valid;
    logic        lookup_hit;
    logic        mem_req_valid;
    logic        mem_req_ready;
    logic        mem_req_write;
    logic [31:0] mem_req_addr;
    logic [31:0] mem_req_data;
    logic        mem_rsp_valid;
    logic [31:0] mem_rsp_data;

    // Reference cache
    logic [25:0] m_tag   [16][4];
    logic [31:0] m_data  [16][4];
    logic        m_valid [16][4];
    logic        m_dirty [16][4];
    logic [2:0]  m_plru  [16];

    logic        exp_hit_q [$];
    logic [31:0] exp_rsp_q [$];
    logic [64:0] exp_mem_q [$];  // Write flag, address, write data

    int          n_mismatch;
    int          n_other;
    int          n_hit;
    int          n_miss;
    int          n_mem_rd;
    int          n_mem_wr;
    logic [31:0] last_rsp;

    cache_top UUT (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_req_valid     (req_valid),
        .o_req_ready     (req_ready),
        .i_req_write     (req_write),
        .i_req_addr      (req_addr),
        .i_req_data      (req_data),
        .i_req_be        (req_be),
        .o_rsp_valid     (rsp_valid),
        .o_rsp_data      (rsp_data),
        .o_lookup_valid  (lookup_valid),
        .o_lookup_hit    (lookup_hit),
        .o_mem_req_valid (mem_req_valid),
        .i_mem_req_ready (mem_req_ready),
        .o_mem_req_write (mem_req_write),
        .o_mem_req_addr  (mem_req_addr),
        .o_mem_req_data  (mem_req_data),
        .i_mem_rsp_valid (mem_rsp_valid),
        .i_mem_rsp_data  (mem_rsp_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic logic [31:0] merge_word(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic logic [1:0] pick_victim(input logic [3:0] set);
        return m_plru[set][0] ? {1'b1, m_plru[set][2]} : {1'b0, m_plru[set][1]};
    endfunction

    function automatic logic [31:0] addr_of(input logic [25:0] tag, input logic [3:0] set);
        return {tag, set, 2'b00};
    endfunction

    task automatic touch_plru(input logic [3:0] set, input logic [1:0] way);
        m_plru[set][0] = ~way[1];  // Root to the other half
        if (way[1]) begin
            m_plru[set][2] = ~way[0];
        end else begin
            m_plru[set][1] = ~way[0];
        end
    endtask

    task automatic predict_request(input logic write, input logic [31:0] addr,
                                   input logic [31:0] data, input logic [3:0] be);
        logic [25:0] tag;
        logic [3:0]  set;
        logic [1:0]  way;
        logic        hit;
        logic [31:0] line_addr;
        tag       = addr[31:6];
        set       = addr[5:2];
        line_addr = {addr[31:2], 2'b00};
        hit       = 1'b0;
        way       = 2'd0;
        for (int w = 0; w < 4; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == tag) begin
                hit = 1'b1;
                way = w[1:0];
            end
        end
        exp_hit_q.push_back(hit);
        if (!hit) begin
            way = pick_victim(set);
            if (m_valid[set][way] && m_dirty[set][way]) begin
                exp_mem_q.push_back({1'b1, m_tag[set][way], set, 2'b00, m_data[set][way]});
            end
            m_tag[set][way]   = tag;
            m_valid[set][way] = 1'b1;
            m_dirty[set][way] = write;
            if (write) begin
                m_data[set][way] = merge_word(32'h0, data, be);  // Unmasked bytes zero
            end else begin
                exp_mem_q.push_back({1'b0, line_addr, 32'h0});
                m_data[set][way] = line_addr ^ MEM_KEY;
            end
        end else if (write) begin
            m_data[set][way]  = merge_word(m_data[set][way], data, be);
            m_dirty[set][way] = 1'b1;
        end
        if (!write) exp_rsp_q.push_back(m_data[set][way]);
        touch_plru(set, way);
    endtask

    ////////////////////////////////////////
    // Memory model and output monitor
    ////////////////////////////////////////
    task automatic serve_memory();
        int          rsp_wait;
        logic [31:0] rsp_addr;
        rsp_wait = 0;
        rsp_addr = 32'h0;
        forever begin
            @(posedge i_clk);
            if (mem_req_valid && mem_req_ready) begin
                if (exp_mem_q.size() == 0) begin
                    n_other++;
                    $display("Unexpected memory request at %0t, address %h", $time, mem_req_addr);
                end else begin
                    if ({mem_req_write, mem_req_addr} !== exp_mem_q[0][64:32] ||
                        (mem_req_write && mem_req_data !== exp_mem_q[0][31:0])) begin
                        n_mismatch++;
                        $display("Mismatch at %0t: memory request %b %h %h, expected %h",
                                 $time, mem_req_write, mem_req_addr, mem_req_data, exp_mem_q[0]);
                    end
                    exp_mem_q.delete(0);
                end
                if (mem_req_write) begin
                    n_mem_wr++;
                end else begin
                    n_mem_rd++;
                    rsp_addr = mem_req_addr;
                    rsp_wait = 2 + int'($urandom % 4);  // 2 to 5 cycles
                end
            end
            #1;
            mem_rsp_valid = 1'b0;
            if (rsp_wait > 0) begin
                rsp_wait--;
                if (rsp_wait == 0) begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp_data  = rsp_addr ^ MEM_KEY;
                end
            end
        end
    endtask

    task automatic watch_outputs();
        forever begin
            @(posedge i_clk);
            if (lookup_valid) begin
                if (exp_hit_q.size() == 0) begin
                    n_other++;
                    $display("Unexpected lookup strobe at %0t", $time);
                end else begin
                    if (lookup_hit !== exp_hit_q[0]) begin
                        n_mismatch++;
                        $display("Mismatch at %0t: lookup hit %b, expected %b",
                                 $time, lookup_hit, exp_hit_q[0]);
                    end
                    exp_hit_q.delete(0);
                end
                if (lookup_hit) n_hit++;
                else n_miss++;
            end
            if (rsp_valid) begin
                last_rsp = rsp_data;
                if (exp_rsp_q.size() == 0) begin
                    n_other++;
                    $display("Unexpected read response at %0t", $time);
                end else begin
                    if (rsp_data !== exp_rsp_q[0]) begin
                        n_mismatch++;
                        $display("Mismatch at %0t: read data %h, expected %h",
                                 $time, rsp_data, exp_rsp_q[0]);
                    end
                    exp_rsp_q.delete(0);
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // Bus driver
    ////////////////////////////////////////
    task automatic send_request(input logic write, input logic [31:0] addr,
                                input logic [31:0] data, input logic [3:0] be);
        int waited;
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_data  = data;
        req_be    = be;
        waited    = 0;
        while (!req_ready && waited < TIMEOUT) begin
            @(posedge i_clk);
            #1;
            waited++;
        end
        if (!req_ready) begin
            n_other++;
            $display("Timeout at %0t: request queue never accepted address %h", $time, addr);
        end else begin
            predict_request(write, addr, data, be);
            @(posedge i_clk);  // Handshake edge
            #1;
        end
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while ((exp_hit_q.size() != 0 || exp_rsp_q.size() != 0 || exp_mem_q.size() != 0) &&
               waited < TIMEOUT) begin
            @(posedge i_clk);
            #1;
            waited++;
        end
        if (exp_hit_q.size() != 0 || exp_rsp_q.size() != 0 || exp_mem_q.size() != 0) begin
            n_other++;
            $display("Timeout at %0t: cache did not finish outstanding requests", $time);
            exp_hit_q.delete();
            exp_rsp_q.delete();
            exp_mem_q.delete();
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////
    task automatic read_miss_then_hit();
        logic [31:0] addr;
        int          rd_before;
        addr      = 32'h0000_1236;  // Offset bits ignored
        rd_before = n_mem_rd;
        send_request(1'b0, addr, 32'h0, 4'h0);
        wait_idle();
        if (n_mem_rd != rd_before + 1 || last_rsp !== (32'h0000_1234 ^ MEM_KEY)) begin
            n_mismatch++;
            $display("Mismatch at %0t: read miss gave %h after %0d memory reads",
                     $time, last_rsp, n_mem_rd - rd_before);
        end
        send_request(1'b0, addr, 32'h0, 4'h0);
        wait_idle();
        if (n_mem_rd != rd_before + 1 || last_rsp !== (32'h0000_1234 ^ MEM_KEY)) begin
            n_mismatch++;
            $display("Mismatch at %0t: read hit gave %h or touched memory", $time, last_rsp);
        end
    endtask

    task automatic write_hit_byte_enables();
        logic [31:0] expect_w;
        int          wr_before;
        wr_before = n_mem_wr;
        expect_w  = ((32'h0000_1234 ^ MEM_KEY) & 32'hff00_ff00) | (32'ha1b2_c3d4 & 32'h00ff_00ff);
        send_request(1'b1, 32'h0000_1234, 32'ha1b2_c3d4, 4'b0101);
        send_request(1'b0, 32'h0000_1234, 32'h0, 4'h0);
        wait_idle();
        if (last_rsp !== expect_w || n_mem_wr != wr_before) begin
            n_mismatch++;
            $display("Mismatch at %0t: merged word %h, expected %h", $time, last_rsp, expect_w);
        end
    endtask

    task automatic plru_eviction();
        logic [25:0] gone;
        int          hit_before;
        int          miss_before;
        for (int i = 0; i < 4; i++) begin
            send_request(1'b0, addr_of(26'h100 + 26'(i), 4'd5), 32'h0, 4'h0);
        end
        send_request(1'b0, addr_of(26'h100, 4'd5), 32'h0, 4'h0);  // Touch the oldest again
        wait_idle();
        gone = m_tag[5][pick_victim(4'd5)];
        send_request(1'b0, addr_of(26'h104, 4'd5), 32'h0, 4'h0);
        wait_idle();
        hit_before  = n_hit;
        miss_before = n_miss;
        for (int i = 0; i < 5; i++) begin
            if (26'h100 + 26'(i) != gone) begin
                send_request(1'b0, addr_of(26'h100 + 26'(i), 4'd5), 32'h0, 4'h0);
            end
        end
        send_request(1'b0, addr_of(gone, 4'd5), 32'h0, 4'h0);
        wait_idle();
        if (n_hit != hit_before + 4 || n_miss != miss_before + 1) begin
            n_mismatch++;
            $display("Mismatch at %0t: re-reads gave %0d hits and %0d misses, expected 4 and 1",
                     $time, n_hit - hit_before, n_miss - miss_before);
        end
    endtask

    task automatic dirty_writeback();
        int wr_before;
        send_request(1'b1, addr_of(26'h200, 4'd9), 32'hdead_beef, 4'b0011);
        send_request(1'b0, addr_of(26'h200, 4'd9), 32'h0, 4'h0);
        wait_idle();
        if (last_rsp !== 32'h0000_beef) begin
            n_mismatch++;
            $display("Mismatch at %0t: write miss installed %h", $time, last_rsp);
        end
        wr_before = n_mem_wr;
        for (int i = 1; i < 5; i++) begin
            send_request(1'b0, addr_of(26'h200 + 26'(i), 4'd9), 32'h0, 4'h0);
        end
        wait_idle();
        if (n_mem_wr != wr_before + 1) begin
            n_mismatch++;
            $display("Mismatch at %0t: %0d writebacks of the Modified line",
                     $time, n_mem_wr - wr_before);
        end
        wr_before = n_mem_wr;
        send_request(1'b0, addr_of(26'h205, 4'd9), 32'h0, 4'h0);  // Evicts a clean line
        wait_idle();
        if (n_mem_wr != wr_before) begin
            n_mismatch++;
            $display("Mismatch at %0t: clean eviction wrote memory", $time);
        end
    endtask

    task automatic mem_backpressure();
        mem_req_ready = 1'b0;
        for (int i = 0; i < 5; i++) begin
            send_request(1'b0, addr_of(26'h300 + 26'(i), 4'(i)), 32'h0, 4'h0);
        end
        if (req_ready) begin
            n_mismatch++;
            $display("Mismatch at %0t: queue still ready while holding four requests", $time);
        end
        mem_req_ready = 1'b1;
        wait_idle();
    endtask

    initial begin
        void'($urandom(SEED));
        i_rst_n       = 1'b0;
        req_valid     = 1'b0;
        req_write     = 1'b0;
        req_addr      = 32'h0;
        req_data      = 32'h0;
        req_be        = 4'h0;
        mem_req_ready = 1'b1;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = 32'h0;
        n_mismatch    = 0;
        n_other       = 0;
        n_hit         = 0;
        n_miss        = 0;
        n_mem_rd      = 0;
        n_mem_wr      = 0;
        last_rsp      = 32'h0;
        for (int s = 0; s < 16; s++) begin
            m_plru[s] = 3'b000;
            for (int w = 0; w < 4; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
        end
        repeat (3) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        fork
            serve_memory();
            watch_outputs();
        join_none
        read_miss_then_hit();
        write_hit_byte_enables();
        plru_eviction();
        dirty_writeback();
        mem_backpressure();
        $display("Errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
